/* common/muu_pkg.sv */
// ********************************************************
// Shared types for the multiply/divide unit: word types,
// opcodes, hi/lo commands and the request and divide-result
// structs. Imported by every block of the unit
// ********************************************************

package muu_pkg;

	// Divider iteration count, one quotient bit per step
	localparam int DIV_STEPS = 32;

	// One operand or result word
	typedef logic [31:0] muu_word_t;

	// hi/lo pair or a full 64-bit product
	typedef logic [63:0] muu_dword_t;

	// Operation codes, values fixed by the core's decoder
	typedef enum logic [3:0] {
		MUL   = 4'd0,  // Signed product, low word to out
		MULT  = 4'd1,  // Signed product to hi/lo
		MADD  = 4'd2,  // hi/lo += signed product
		MSUBU = 4'd3,  // hi/lo -= unsigned product
		DIV   = 4'd4,  // Signed divide, quot to lo, rem to hi
		MFHI  = 4'd5,  // out = hi
		MFLO  = 4'd6,  // out = lo
		CLO   = 4'd7,  // Count leading ones of rs
		NOP   = 4'd15  // Idle
	} muu_op_e;

	// Request presented by the core, sampled every edge
	typedef struct packed {
		muu_op_e   op;  // Opcode
		muu_word_t rs;  // First operand
		muu_word_t rt;  // Second operand
	} muu_req_t;

	// What the accumulator does with the product this cycle
	typedef enum logic [1:0] {
		HILO_NONE = 2'd0,  // Hold
		HILO_SET  = 2'd1,  // Load product
		HILO_ADD  = 2'd2,  // Accumulate product
		HILO_SUBU = 2'd3   // Subtract product, 64-bit borrow
	} muu_hilo_cmd_e;

	// Divider output, valid with div_done
	typedef struct packed {
		muu_word_t quot;  // Quotient, truncated toward zero
		muu_word_t rem;   // Remainder, sign of dividend
	} muu_div_res_t;

endpackage

/* hw/div/muu_div.sv */
// ********************************************************
// Iterative signed divider. Restoring shift-subtract on the
// operand magnitudes gives one quotient bit per cycle. Start
// with a nonzero divisor and take the result with div_done
// ********************************************************

module muu_div (
	input  logic                  clk,
	input  logic                  reset,
	input  logic                  div_start,  // Latch operands and begin
	input  muu_pkg::muu_word_t    rs,         // Dividend
	input  muu_pkg::muu_word_t    rt,         // Nonzero divisor
	output logic                  busy,       // Run in progress
	output logic                  div_done,   // Last step this cycle
	output muu_pkg::muu_div_res_t div_res     // Signed result
);
	import muu_pkg::*;

	typedef enum logic {
		DIV_IDLE,
		DIV_RUN
	} div_state_e;

	div_state_e                     state_q;
	logic [$clog2(DIV_STEPS)-1:0]   step_cnt;    // Steps done so far
	muu_word_t                      divisor_q;   // |rt|
	muu_word_t                      rem_q;       // Partial remainder
	muu_word_t                      quot_q;      // Dividend bits shifting out
	logic                           quot_neg_q;  // Signs differ
	logic                           rem_neg_q;   // Dividend negative
	logic [32:0]                    shifted;     // Remainder with next bit
	logic                           fits;        // Divisor fits and sets the quotient bit
	muu_word_t                      rem_next;
	muu_word_t                      quot_next;
	logic                           last_step;

	function automatic muu_word_t magnitude(input muu_word_t w);
		return w[31] ? -w : w;  // 0x80000000 stays as 2^31 unsigned
	endfunction

	// One restoring step
	assign shifted   = {rem_q, quot_q[31]};
	assign fits      = (shifted >= {1'b0, divisor_q});
	assign rem_next  = fits ? muu_word_t'(shifted - {1'b0, divisor_q}) : shifted[31:0];
	assign quot_next = {quot_q[30:0], fits};

	assign last_step = (step_cnt == $bits(step_cnt)'(DIV_STEPS - 1));
	assign busy      = (state_q == DIV_RUN);
	assign div_done  = busy && last_step;

	// Sign fixup on the final step's values
	assign div_res.quot = quot_neg_q ? -quot_next : quot_next;  // Most-negative / -1 wraps
	assign div_res.rem  = rem_neg_q ? -rem_next : rem_next;

	// Control state
	always_ff @(posedge clk) begin
		if (reset) begin
			state_q  <= DIV_IDLE;
			step_cnt <= '0;
		end else begin
			case (state_q)
				DIV_IDLE: begin
					step_cnt <= '0;
					if (div_start)
						state_q <= DIV_RUN;
				end
				DIV_RUN: begin
					step_cnt <= step_cnt + 1'b1;
					if (last_step)
						state_q <= DIV_IDLE;  // busy falls with writeback
				end
				default: state_q <= DIV_IDLE;
			endcase
		end
	end

	// Operand and partial result registers
	always_ff @(posedge clk) begin
		if (state_q == DIV_IDLE && div_start) begin
			divisor_q  <= magnitude(rt);
			quot_q     <= magnitude(rs);
			rem_q      <= '0;
			quot_neg_q <= rs[31] ^ rt[31];
			rem_neg_q  <= rs[31];  // Remainder follows dividend
		end else if (busy) begin
			rem_q  <= rem_next;
			quot_q <= quot_next;
		end
	end

endmodule

/* hw/hilo/muu_hilo_acc.sv */
// ********************************************************
// hi/lo accumulator pair. Forms the 64-bit product of rs and
// rt and applies the control's command to hi/lo; also loads
// the divider's result when div_done pulses
// ********************************************************

module muu_hilo_acc (
	input  logic                   clk,
	input  logic                   reset,
	input  muu_pkg::muu_hilo_cmd_e hilo_cmd,    // What to do this cycle
	input  logic                   signed_mul,  // Sign-extend operands
	input  muu_pkg::muu_word_t     rs,          // Multiplicand
	input  muu_pkg::muu_word_t     rt,          // Multiplier
	input  logic                   div_done,    // Divide result valid
	input  muu_pkg::muu_div_res_t  div_res,     // Quotient and remainder
	output muu_pkg::muu_word_t     prod_lo,     // Low product word
	output muu_pkg::muu_word_t     hi,          // High accumulator word
	output muu_pkg::muu_word_t     lo           // Low accumulator word
);
	import muu_pkg::*;

	muu_dword_t rs_ext;   // rs widened to 64 bits
	muu_dword_t rt_ext;   // rt widened to 64 bits
	muu_dword_t product;  // Full product, low 64 bits
	muu_dword_t hilo_q;   // {hi, lo}
	muu_dword_t hilo_d;   // Next {hi, lo}

	// One multiplier serves both signed and unsigned forms.
	// With sign extension to 64 bits, the low 64 bits of the
	// product equal the signed product
	assign rs_ext = {{32{signed_mul & rs[31]}}, rs};
	assign rt_ext = {{32{signed_mul & rt[31]}}, rt};
	assign product = rs_ext * rt_ext;  // Truncated to 64 bits

	assign prod_lo = product[31:0];  // For MUL's out

	always_comb begin
		hilo_d = hilo_q;  // Hold by default
		if (div_done) begin
			hilo_d = {div_res.rem, div_res.quot};  // rem to hi, quot to lo
		end else begin
			case (hilo_cmd)
				HILO_SET:  hilo_d = product;
				HILO_ADD:  hilo_d = hilo_q + product;
				HILO_SUBU: hilo_d = hilo_q - product;  // Borrow lo into hi
				default:   hilo_d = hilo_q;
			endcase
		end
	end

	// Commands are blocked while busy, so div_done never meets one
	always_ff @(posedge clk) begin
		if (reset) begin
			hilo_q <= '0;
		end else begin
			hilo_q <= hilo_d;
		end
	end

	assign hi = hilo_q[63:32];
	assign lo = hilo_q[31:0];

endmodule

/* hw/muu_ctrl.sv */
// ********************************************************
// Control of the multiply/divide unit. Decodes the opcode,
// blocks issue while the divider is busy, computes CLO and
// registers out and the divide-by-zero flag
// ********************************************************

module muu_ctrl (
	input  logic                   clk,
	input  logic                   reset,
	input  muu_pkg::muu_req_t      req,         // Incoming request
	input  logic                   busy,        // Divider running
	input  muu_pkg::muu_word_t     hi,          // Current hi
	input  muu_pkg::muu_word_t     lo,          // Current lo
	input  muu_pkg::muu_word_t     prod_lo,     // Low product word
	output muu_pkg::muu_hilo_cmd_e hilo_cmd,    // Accumulator command
	output logic                   signed_mul,  // Signed multiply
	output logic                   div_start,   // Divider start pulse
	output muu_pkg::muu_word_t     out,         // Registered result
	output logic                   div_zero     // Zero divisor seen
);
	import muu_pkg::*;

	muu_op_e   issue_op;   // Opcode after busy blocking
	logic      rt_zero;    // Divisor is zero
	muu_word_t clo_count;  // Leading ones of rs

	// Priority scan from the MSB, stops at the first zero bit
	function automatic muu_word_t count_lead_ones(input muu_word_t w);
		muu_word_t cnt;
		logic      found;
		cnt   = muu_word_t'(32);  // All ones unless a zero is found
		found = 1'b0;
		for (int i = 31; i >= 0; i--) begin
			if (!found && !w[i]) begin
				cnt   = muu_word_t'(31 - i);
				found = 1'b1;
			end
		end
		return cnt;
	endfunction

	// Requests arriving during a divide are dropped here
	assign issue_op  = busy ? NOP : req.op;
	assign rt_zero   = (req.rt == '0);
	assign clo_count = count_lead_ones(req.rs);

	// Only MSUBU multiplies unsigned
	assign signed_mul = (req.op != MSUBU);

	always_comb begin
		hilo_cmd  = HILO_NONE;
		div_start = 1'b0;
		case (issue_op)
			MUL, MULT: hilo_cmd  = HILO_SET;
			MADD:      hilo_cmd  = HILO_ADD;
			MSUBU:     hilo_cmd  = HILO_SUBU;
			DIV:       div_start = !rt_zero;  // Divider never sees zero
			default:   hilo_cmd  = HILO_NONE;
		endcase
	end

	// out only changes for ops that produce a word
	always_ff @(posedge clk) begin
		if (reset) begin
			out <= '0;
		end else begin
			case (issue_op)
				MUL:     out <= prod_lo;    // Same cycle product
				MFHI:    out <= hi;         // Value at issue edge
				MFLO:    out <= lo;
				CLO:     out <= clo_count;
				default: out <= out;        // Hold
			endcase
		end
	end

	// One-cycle pulse, hi/lo are left alone
	always_ff @(posedge clk) begin
		if (reset) begin
			div_zero <= 1'b0;
		end else begin
			div_zero <= (issue_op == DIV) && rt_zero;
		end
	end

endmodule

/* hw/muu_top.sv */
// ********************************************************
// Top level of the multiply/divide unit. The core presents
// one request per cycle and watches busy while a divide runs
// ********************************************************

module muu_top (
	input  logic               clk,
	input  logic               reset,
	input  muu_pkg::muu_req_t  req,       // Opcode and operands
	output muu_pkg::muu_word_t out,       // Result for the register file
	output muu_pkg::muu_word_t hi,        // Accumulator high word
	output muu_pkg::muu_word_t lo,        // Accumulator low word
	output logic               div_zero,  // Divide by zero, one cycle
	output logic               busy       // Divider running
);
	import muu_pkg::*;

	muu_hilo_cmd_e hilo_cmd;    // Accumulator command
	logic          signed_mul;  // Signed multiply select
	logic          div_start;   // Start pulse to divider
	logic          div_done;    // Divider finished this cycle
	muu_word_t     prod_lo;     // Low product word for MUL
	muu_div_res_t  div_res;     // Quotient and remainder

	muu_ctrl muu_ctrl_i (
		.clk        (clk),
		.reset      (reset),
		.req        (req),
		.busy       (busy),
		.hi         (hi),
		.lo         (lo),
		.prod_lo    (prod_lo),
		.hilo_cmd   (hilo_cmd),
		.signed_mul (signed_mul),
		.div_start  (div_start),
		.out        (out),
		.div_zero   (div_zero)
	);

	// Operands go straight from the request to both datapaths
	muu_hilo_acc muu_hilo_acc_i (
		.clk        (clk),
		.reset      (reset),
		.hilo_cmd   (hilo_cmd),
		.signed_mul (signed_mul),
		.rs         (req.rs),
		.rt         (req.rt),
		.div_done   (div_done),
		.div_res    (div_res),
		.prod_lo    (prod_lo),
		.hi         (hi),
		.lo         (lo)
	);

	muu_div muu_div_i (
		.clk       (clk),
		.reset     (reset),
		.div_start (div_start),
		.rs        (req.rs),
		.rt        (req.rt),
		.busy      (busy),
		.div_done  (div_done),
		.div_res   (div_res)
	);

endmodule

/* verification/muu_checker.sv */
// ********************************************************
// Assertions on the multiply/divide unit, bound into the top
// level: divide busy length, div_zero pulse width, and hi/lo
// held while the divider runs
// ********************************************************

module muu_checker (
	input logic               clk,
	input logic               reset,
	input logic               busy,
	input logic               div_zero,
	input muu_pkg::muu_word_t hi,
	input muu_pkg::muu_word_t lo
);
	timeunit 1ns;
	timeprecision 1ps;
	import muu_pkg::*;

	int busy_run;  // Consecutive busy cycles before this edge

	always_ff @(posedge clk) begin
		if (reset) begin
			busy_run <= 0;
		end else if (busy) begin
			busy_run <= busy_run + 1;
		end else begin
			busy_run <= 0;
		end
	end

	// A finished run lasted exactly the step count
	busy_len_a: assert property (@(posedge clk) disable iff (reset)
		(!busy && busy_run != 0) |-> (busy_run == DIV_STEPS))
		else $error("busy fell after the wrong number of cycles");

	busy_max_a: assert property (@(posedge clk) disable iff (reset)
		busy |-> (busy_run < DIV_STEPS))
		else $error("busy stayed high longer than the divide");

	div_zero_pulse_a: assert property (@(posedge clk) disable iff (reset)
		div_zero |=> !div_zero)
		else $error("div_zero stayed high for two cycles");

	// Blocked issue, writeback only when busy falls
	hilo_hold_a: assert property (@(posedge clk) disable iff (reset)
		busy |-> ($stable(hi) && $stable(lo)))
		else $error("hi or lo changed while the divider was busy");

endmodule

bind muu_top muu_checker muu_checker_i (
	.clk      (clk),
	.reset    (reset),
	.busy     (busy),
	.div_zero (div_zero),
	.hi       (hi),
	.lo       (lo)
);

/* verification/muu_tb.sv */
// ********************************************************
// Testbench for the multiply/divide unit. Builds a request
// table, fills in expected results from a reference model,
// then drives the table through the DUT and checks each row
// ********************************************************

module muu_tb;
	timeunit 1ns;
	timeprecision 1ps;
	import muu_pkg::*;

	localparam int CLK_PERIOD   = 100;
	localparam int RESET_CYCLES = 3;
	localparam int NUM_RANDOM   = 8;   // LFSR rows after the fixed ones
	localparam muu_req_t IDLE_REQ = '{op: NOP, rs: '0, rt: '0};

	typedef struct packed {
		muu_req_t  req;           // Request under test
		muu_req_t  shadow;        // Issued while the divider runs
		muu_word_t exp_out;
		muu_word_t exp_hi;
		muu_word_t exp_lo;
		logic      exp_div_zero;
	} table_entry_t;

	logic         clk;
	logic         reset;
	muu_req_t     req;
	muu_word_t    out;
	muu_word_t    hi;
	muu_word_t    lo;
	logic         div_zero;
	logic         busy;
	table_entry_t stim_table[$];
	logic [31:0]  lfsr_state;
	logic         table_ready;       // Watchdog starts once sized
	logic         run_complete;
	logic         failure_reported;

	muu_top muu_top_i (
		.clk      (clk),
		.reset    (reset),
		.req      (req),
		.out      (out),
		.hi       (hi),
		.lo       (lo),
		.div_zero (div_zero),
		.busy     (busy)
	);

	initial begin
		clk = 1'b0;
		forever #(CLK_PERIOD / 2) clk = ~clk;
	end

	task automatic report_failure(input string msg);
		failure_reported = 1'b1;
		$display("%s", msg);
		$display("TEST FAILED");
		$fatal(1, "Stopping at first failure");
	endtask

	task automatic check_word(input string name, input muu_word_t got, input muu_word_t exp);
		if (got !== exp)
			report_failure($sformatf("Error: %s is 0x%08h, expected 0x%08h", name, got, exp));
	endtask

	task automatic check_flag(input string name, input logic got, input logic exp);
		if (got !== exp)
			report_failure($sformatf("Error: %s is 0x%0h, expected 0x%0h", name, got, exp));
	endtask

	// Right-shift Galois form, x^32 + x^22 + x^2 + x + 1
	function automatic logic [31:0] galois_step(input logic [31:0] s);
		return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
	endfunction

	task automatic draw_bits(input int n, output muu_word_t w);
		w = '0;
		for (int i = 0; i < n; i++) begin
			lfsr_state = galois_step(lfsr_state);  // One step per bit
			w = {w[30:0], lfsr_state[0]};
		end
	endtask

	function automatic muu_req_t make_req(input muu_op_e op, input muu_word_t rs,
		input muu_word_t rt);
		muu_req_t r;
		r.op = op;
		r.rs = rs;
		r.rt = rt;
		return r;
	endfunction

	task automatic push_entry(input muu_req_t r, input muu_req_t s);
		table_entry_t e;
		e        = '0;
		e.req    = r;
		e.shadow = s;
		stim_table.push_back(e);
	endtask

	// Reference arithmetic on 64-bit signed values
	function automatic muu_dword_t ref_smul(input muu_word_t a, input muu_word_t b);
		logic signed [63:0] sa;
		logic signed [63:0] sb;
		sa = 64'($signed(a));
		sb = 64'($signed(b));
		return muu_dword_t'(sa * sb);
	endfunction

	function automatic muu_div_res_t ref_div(input muu_word_t a, input muu_word_t b);
		logic signed [63:0] sa;
		logic signed [63:0] sb;
		muu_div_res_t       r;
		sa     = 64'($signed(a));
		sb     = 64'($signed(b));
		r.quot = muu_word_t'(sa / sb);  // Wide, so min / -1 just wraps
		r.rem  = muu_word_t'(sa % sb);
		return r;
	endfunction

	function automatic muu_word_t ref_clo(input muu_word_t w);
		muu_word_t n;
		muu_word_t v;
		n = '0;
		v = w;
		while (v[31]) begin
			n = n + 1;
			v = v << 1;
		end
		return n;
	endfunction

	task automatic build_table();
		muu_word_t sel;
		muu_word_t a;
		muu_word_t b;
		push_entry(make_req(MUL, 32'hffff_fffd, 32'd7), IDLE_REQ);          // -3 * 7
		push_entry(make_req(MULT, 32'h8000_0000, 32'h8000_0000), IDLE_REQ);
		push_entry(make_req(MFHI, 32'd0, 32'd0), IDLE_REQ);
		push_entry(make_req(MFLO, 32'd0, 32'd0), IDLE_REQ);
		push_entry(make_req(MULT, 32'h8000_0000, 32'hffff_ffff), IDLE_REQ);
		push_entry(make_req(MUL, 32'd0, 32'h1234_5678), IDLE_REQ);
		push_entry(make_req(MULT, 32'd1, 32'h10), IDLE_REQ);
		push_entry(make_req(MSUBU, 32'h20, 32'd1), IDLE_REQ);               // Borrow into hi
		push_entry(make_req(MADD, 32'hffff_ffff, 32'hffff_ffff), IDLE_REQ);
		push_entry(make_req(MSUBU, 32'hffff_ffff, 32'hffff_ffff), IDLE_REQ);
		push_entry(make_req(MFLO, 32'd0, 32'd0), IDLE_REQ);
		push_entry(make_req(DIV, 32'd100, 32'd7), make_req(MULT, 32'd5, 32'd6));
		push_entry(make_req(DIV, 32'hffff_ff9c, 32'd7), make_req(MFHI, 32'd0, 32'd0));
		push_entry(make_req(DIV, 32'd100, 32'hffff_fff9), make_req(CLO, 32'hffff_ffff, 32'd0));
		push_entry(make_req(DIV, 32'hffff_ff9c, 32'hffff_fff9), IDLE_REQ);
		push_entry(make_req(DIV, 32'h8000_0000, 32'hffff_ffff), make_req(DIV, 32'd9, 32'd3));
		push_entry(make_req(DIV, 32'd7, 32'd100), make_req(MADD, 32'd3, 32'd3));
		push_entry(make_req(DIV, 32'd5, 32'd0), IDLE_REQ);                  // Zero divisor
		push_entry(make_req(MFHI, 32'd0, 32'd0), IDLE_REQ);
		push_entry(make_req(CLO, 32'hffff_ffff, 32'd0), IDLE_REQ);
		push_entry(make_req(CLO, 32'd0, 32'd0), IDLE_REQ);
		push_entry(make_req(CLO, 32'hf0f0_f0f0, 32'd0), IDLE_REQ);
		push_entry(make_req(CLO, 32'hfffe_0000, 32'd0), IDLE_REQ);
		push_entry(make_req(NOP, 32'h1111_1111, 32'h2222_2222), IDLE_REQ);
		push_entry(make_req(muu_op_e'(4'd9), 32'h3333_3333, 32'd4), IDLE_REQ);  // Unused code
		for (int i = 0; i < NUM_RANDOM; i++) begin
			draw_bits(3, sel);   // Opcodes 0 to 7
			draw_bits(32, a);
			draw_bits(32, b);
			push_entry(make_req(muu_op_e'(sel[3:0]), a, b), IDLE_REQ);
		end
	endtask

	// Runs the rules over the table in order, hi/lo carry across rows
	task automatic fill_expected();
		muu_dword_t   acc;
		muu_word_t    m_out;
		muu_div_res_t dres;
		table_entry_t e;
		acc   = '0;
		m_out = '0;
		for (int i = 0; i < stim_table.size(); i++) begin
			e              = stim_table[i];
			e.exp_div_zero = 1'b0;
			case (e.req.op)
				MUL: begin
					acc   = ref_smul(e.req.rs, e.req.rt);
					m_out = acc[31:0];
				end
				MULT:  acc = ref_smul(e.req.rs, e.req.rt);
				MADD:  acc = acc + ref_smul(e.req.rs, e.req.rt);
				MSUBU: acc = acc - (64'(e.req.rs) * 64'(e.req.rt));
				DIV: begin
					if (e.req.rt == '0) begin
						e.exp_div_zero = 1'b1;  // hi/lo stay
					end else begin
						dres = ref_div(e.req.rs, e.req.rt);
						acc  = {dres.rem, dres.quot};
					end
				end
				MFHI:    m_out = acc[63:32];
				MFLO:    m_out = acc[31:0];
				CLO:     m_out = ref_clo(e.req.rs);
				default: acc = acc;  // No-operation
			endcase
			e.exp_out     = m_out;
			e.exp_hi      = acc[63:32];
			e.exp_lo      = acc[31:0];
			stim_table[i] = e;
		end
	endtask

	task automatic apply_entry(input table_entry_t e, input muu_word_t prev_out,
		input muu_word_t prev_hi, input muu_word_t prev_lo);
		int   busy_cycles;
		int   expect_busy;
		logic div_runs;
		div_runs    = (e.req.op == DIV) && (e.req.rt != '0);
		expect_busy = div_runs ? DIV_STEPS : 0;
		busy_cycles = 0;
		@(posedge clk);
		req <= e.req;
		@(posedge clk);                          // Issue edge
		req <= div_runs ? e.shadow : IDLE_REQ;
		@(negedge clk);
		while (busy) begin
			busy_cycles++;
			if (busy_cycles > DIV_STEPS)
				report_failure("Error: busy stayed high past the divide length");
			check_word("out", out, prev_out);      // Blocked requests change nothing
			check_word("hi", hi, prev_hi);
			check_word("lo", lo, prev_lo);
			@(posedge clk);
			req <= (busy_cycles < DIV_STEPS) ? e.shadow : IDLE_REQ;
			@(negedge clk);
		end
		if (busy_cycles != expect_busy)
			report_failure($sformatf("Error: busy lasted %0d cycles instead of %0d",
				busy_cycles, expect_busy));
		check_word("out", out, e.exp_out);
		check_word("hi", hi, e.exp_hi);
		check_word("lo", lo, e.exp_lo);
		check_flag("div_zero", div_zero, e.exp_div_zero);
		if (e.exp_div_zero) begin
			@(negedge clk);
			check_flag("div_zero", div_zero, 1'b0);  // Single-cycle pulse
		end
	endtask

	initial begin
		reset            = 1'b1;
		req              = IDLE_REQ;
		table_ready      = 1'b0;
		run_complete     = 1'b0;
		failure_reported = 1'b0;
		lfsr_state       = 32'd43;
		build_table();
		fill_expected();
		table_ready = 1'b1;
		repeat (RESET_CYCLES) @(posedge clk);
		reset <= 1'b0;
		@(negedge clk);
		check_word("out", out, '0);
		check_word("hi", hi, '0);
		check_word("lo", lo, '0);
		check_flag("busy", busy, 1'b0);
		check_flag("div_zero", div_zero, 1'b0);
		apply_entry(stim_table[0], '0, '0, '0);
		for (int i = 1; i < stim_table.size(); i++)
			apply_entry(stim_table[i], stim_table[i-1].exp_out, stim_table[i-1].exp_hi,
				stim_table[i-1].exp_lo);
		run_complete = 1'b1;
		$display("TEST PASSED");
		$finish;
	end

	// Worst row is a full divide plus issue and check cycles
	initial begin
		wait (table_ready);
		repeat (RESET_CYCLES + 4 + stim_table.size() * (DIV_STEPS + 4)) @(posedge clk);
		report_failure("Error: timeout, the test table did not finish in time");
	end

	// Run stopped early, for instance by a failed assertion
	final begin
		if (!run_complete && !failure_reported) begin
			$display("Error: simulation ended before the test table completed");
			$display("TEST FAILED");
		end
	end

endmodule

/* build.f */
common/muu_pkg.sv
hw/div/muu_div.sv
hw/hilo/muu_hilo_acc.sv
hw/muu_ctrl.sv
hw/muu_top.sv
verification/muu_checker.sv
verification/muu_tb.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= muu_tb
FILELIST  ?= build.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ps

SRCS    := $(shell grep -v '^+' $(FILELIST))
SIM_BIN := $(OBJ_DIR)/V$(TOP)

.PHONY: all build run clean

all: run

build: $(SIM_BIN)

$(SIM_BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	$(SIM_BIN) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "TEST FAILED" $(LOG); then echo "Simulation reported failure"; exit 1; fi
	@if ! grep -q "TEST PASSED" $(LOG); then echo "No verdict in $(LOG)"; exit 1; fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
